/* hdl/xdma_link_consts.svh */
/*
 * xdma link constants
 * bus widths, cluster address map, message windows and depths
 */
`ifndef XDMA_LINK_CONSTS_SVH
`define XDMA_LINK_CONSTS_SVH

// bus widths
`define XDMA_ADDR_W 32
`define XDMA_DATA_W 64
`define XDMA_ID_W 8
`define XDMA_LEN_W 8

// cluster map, every cluster owns one aligned space
`define XDMA_CLUSTER_BASE 32'h1000_0000
`define XDMA_CLUSTER_SPACE 32'h0010_0000
`define XDMA_CLUSTER_SHIFT 20

// message windows, counted down from the cluster end
`define XDMA_WIN_SIZE 4096
`define XDMA_WIN_DATA 0
`define XDMA_WIN_CFG 1
`define XDMA_WIN_GRANT 2

// grant store entries and number of outbound senders
`define XDMA_GRANT_DEPTH 4
`define XDMA_N_SENDERS 3

`endif

/* hdl/xdma_link_pkg.sv */
/*
 * xdma link package
 * message and bus word types, plus the window address rule
 * shared by all senders and the receiver
 */
`default_nettype none

package xdma_link_pkg;

`include "xdma_link_consts.svh"

  typedef logic [`XDMA_ADDR_W-1:0] addr_t;
  typedef logic [`XDMA_DATA_W-1:0] data_t;
  typedef logic [`XDMA_ID_W-1:0] id_t;
  typedef logic [`XDMA_LEN_W-1:0] len_t;

  // one write on either bus
  typedef struct packed {
    addr_t addr;
    data_t data;
  } xdma_wr_t;

  // configuration message, exactly one data word
  typedef struct packed {
    id_t                                          dma_id;
    // 0 read, 1 write
    logic                                         dma_type;
    addr_t                                        peer_addr;
    logic [`XDMA_DATA_W-`XDMA_ID_W-`XDMA_ADDR_W-2:0] pad;
  } xdma_cfg_t;

  // grant message, from_addr is the granting cluster base
  typedef struct packed {
    id_t                                          dma_id;
    addr_t                                        from_addr;
    logic [`XDMA_DATA_W-`XDMA_ID_W-`XDMA_ADDR_W-1:0] pad;
  } xdma_grant_t;

  // local decision to accept a transfer
  typedef struct packed {
    id_t   dma_id;
    addr_t src_addr;
  } xdma_accept_t;

  // data job, len in words, never 0
  typedef struct packed {
    id_t   dma_id;
    addr_t dst_addr;
    len_t  len;
  } xdma_burst_t;

  // start of window win in the cluster that holds addr
  function automatic addr_t xdma_win_addr(addr_t addr, int unsigned win);
    addr_t base;
    base = `XDMA_CLUSTER_BASE +
           (((addr - `XDMA_CLUSTER_BASE) >> `XDMA_CLUSTER_SHIFT) << `XDMA_CLUSTER_SHIFT);
    return base + `XDMA_CLUSTER_SPACE - addr_t'((win + 1) * `XDMA_WIN_SIZE);
  endfunction

endpackage

`default_nettype wire

/* hdl/xdma_cfg_sender.sv */
/*
 * xdma cfg sender
 * registers one configuration as a single write into the
 * cfg window of the cluster that holds peer_addr
 */
`timescale 1ns/1ps
`default_nettype none
`include "xdma_link_consts.svh"

module xdma_cfg_sender
  import xdma_link_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  xdma_cfg_t cfg_i,
  input  logic      cfg_valid_i,
  output logic      cfg_ready_o,
  output xdma_wr_t  wr_o,
  output logic      wr_valid_o,
  input  logic      wr_ready_i
);

  xdma_wr_t  wr_q;
  logic      valid_q;
  logic      take;
  xdma_cfg_t msg;

  // free slot, or the slot drains this cycle
  assign cfg_ready_o = !valid_q || wr_ready_i;
  assign take        = cfg_valid_i && cfg_ready_o;

  // padding always goes out as zero
  always_comb begin
    msg     = cfg_i;
    msg.pad = '0;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (wr_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      wr_q.addr <= xdma_win_addr(cfg_i.peer_addr, `XDMA_WIN_CFG);
      wr_q.data <= data_t'(msg);
    end
  end

  assign wr_o       = wr_q;
  assign wr_valid_o = valid_q;

endmodule

`default_nettype wire

/* hdl/xdma_grant_issuer.sv */
/*
 * xdma grant issuer
 * builds a grant for an accepted transfer and sends it to the
 * grant window of the source cluster
 */
`timescale 1ns/1ps
`default_nettype none
`include "xdma_link_consts.svh"

module xdma_grant_issuer
  import xdma_link_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  xdma_accept_t accept_i,
  input  logic         accept_valid_i,
  output logic         accept_ready_o,
  input  addr_t        cluster_base_i,
  output xdma_wr_t     wr_o,
  output logic         wr_valid_o,
  input  logic         wr_ready_i
);

  xdma_wr_t    wr_q;
  logic        valid_q;
  logic        take;
  xdma_grant_t grant;

  assign accept_ready_o = !valid_q || wr_ready_i;
  assign take           = accept_valid_i && accept_ready_o;

  // grant tells the source which cluster is ready for it
  always_comb begin
    grant.dma_id    = accept_i.dma_id;
    grant.from_addr = cluster_base_i;
    grant.pad       = '0;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (wr_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      wr_q.addr <= xdma_win_addr(accept_i.src_addr, `XDMA_WIN_GRANT);
      wr_q.data <= data_t'(grant);
    end
  end

  assign wr_o       = wr_q;
  assign wr_valid_o = valid_q;

endmodule

`default_nettype wire

/* hdl/xdma_data_sender.sv */
/*
 * xdma data sender
 * keeps received grants in a small circular store and streams a
 * burst to the peer data window once the head grant matches its id
 * pulses done_o one cycle after the last word
 */
`timescale 1ns/1ps
`default_nettype none
`include "xdma_link_consts.svh"

module xdma_data_sender
  import xdma_link_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  xdma_burst_t burst_i,
  input  logic        burst_valid_i,
  output logic        burst_ready_o,
  input  data_t       word_i,
  input  logic        word_valid_i,
  output logic        word_ready_o,
  input  xdma_grant_t grant_i,
  input  logic        grant_valid_i,
  output logic        grant_ready_o,
  output xdma_wr_t    wr_o,
  output logic        wr_valid_o,
  input  logic        wr_ready_i,
  output logic        done_o
);

  localparam int unsigned Depth = `XDMA_GRANT_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  // ------------------------------------------------------------------
  // grant store
  // ------------------------------------------------------------------
  // only the id matters for gating
  id_t             store_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  // ------------------------------------------------------------------
  // current job
  // ------------------------------------------------------------------
  xdma_burst_t job_q;
  logic        busy_q;
  len_t        idx_q;
  logic        done_q;
  logic        granted;
  logic        fire;
  logic        last;

  assign grant_ready_o = (count_q != CntW'(Depth));
  assign push          = grant_valid_i && grant_ready_o;

  // head grant must carry our id
  assign granted = busy_q && (count_q != '0) && (store_q[rd_ptr_q] == job_q.dma_id);

  assign burst_ready_o = !busy_q;
  assign wr_valid_o    = granted && word_valid_i;
  assign word_ready_o  = granted && wr_ready_i;
  assign fire          = wr_valid_o && wr_ready_i;
  assign last          = (idx_q == job_q.len - 1'b1);
  assign pop           = fire && last;

  // 8 bytes per word into the peer data window
  assign wr_o.addr = xdma_win_addr(job_q.dst_addr, `XDMA_WIN_DATA) + (addr_t'(idx_q) << 3);
  assign wr_o.data = word_i;
  assign done_o    = done_q;

  always_ff @(posedge clk_i) begin
    if (push) begin
      store_q[wr_ptr_q] <= grant_i.dma_id;
    end
    if (burst_valid_i && burst_ready_o) begin
      job_q <= burst_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      busy_q   <= 1'b0;
      idx_q    <= '0;
      done_q   <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
      // new job starts at word 0
      if (burst_valid_i && burst_ready_o) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else if (pop) begin
        busy_q <= 1'b0;
      end else if (fire) begin
        idx_q <= idx_q + 1'b1;
      end
      done_q <= pop;
    end
  end

endmodule

`default_nettype wire

/* hdl/xdma_write_arbiter.sv */
/*
 * xdma write arbiter
 * round-robin arbitration of several senders onto one write bus
 * a presented choice is locked until its handshake
 */
`timescale 1ns/1ps
`default_nettype none
`include "xdma_link_consts.svh"

module xdma_write_arbiter
  import xdma_link_pkg::*;
#(
  parameter type         payload_t = xdma_wr_t,
  parameter int unsigned NumReq    = `XDMA_N_SENDERS
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  payload_t          req_i [NumReq],
  input  logic [NumReq-1:0] req_valid_i,
  output logic [NumReq-1:0] req_ready_o,
  output payload_t          oup_o,
  output logic              oup_valid_o,
  input  logic              oup_ready_i
);

  localparam int unsigned IdxW = (NumReq > 1) ? $clog2(NumReq) : 1;

  logic [IdxW-1:0] prio_q;
  logic [IdxW-1:0] rr_idx;
  logic [IdxW-1:0] sel_idx;
  logic [IdxW-1:0] lock_idx_q;
  logic            lock_q;
  logic            fire;

  // first valid requester at or after prio_q
  always_comb begin : proc_rr_pick
    int unsigned cand;
    logic        found;
    found  = 1'b0;
    rr_idx = prio_q;
    for (int unsigned i = 0; i < NumReq; i++) begin
      cand = prio_q + i;
      if (cand >= NumReq) begin
        cand = cand - NumReq;
      end
      if (!found && req_valid_i[cand]) begin
        found  = 1'b1;
        rr_idx = IdxW'(cand);
      end
    end
  end

  // locked choice wins over a fresh pick
  assign sel_idx     = lock_q ? lock_idx_q : rr_idx;
  assign oup_o       = req_i[sel_idx];
  assign oup_valid_o = req_valid_i[sel_idx];
  assign fire        = oup_valid_o && oup_ready_i;

  always_comb begin
    req_ready_o          = '0;
    req_ready_o[sel_idx] = oup_ready_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (fire) begin
      lock_q <= 1'b0;
      // priority moves past the winner
      prio_q <= (sel_idx == IdxW'(NumReq - 1)) ? '0 : sel_idx + 1'b1;
    end else if (oup_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

endmodule

`default_nettype wire

/* hdl/xdma_write_receiver.sv */
/*
 * xdma write receiver
 * matches inbound writes against the local data, cfg and grant
 * windows and routes each to its output, writes outside every
 * window are taken and dropped
 */
`timescale 1ns/1ps
`default_nettype none
`include "xdma_link_consts.svh"

module xdma_write_receiver
  import xdma_link_pkg::*;
(
  input  addr_t       cluster_base_i,
  input  xdma_wr_t    in_wr_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  output xdma_cfg_t   cfg_o,
  output logic        cfg_valid_o,
  input  logic        cfg_ready_i,
  output data_t       data_o,
  output logic        data_valid_o,
  input  logic        data_ready_i,
  output xdma_grant_t grant_o,
  output logic        grant_valid_o,
  input  logic        grant_ready_i
);

  addr_t data_win;
  addr_t cfg_win;
  addr_t grant_win;
  logic  hit_data;
  logic  hit_cfg;
  logic  hit_grant;

  function automatic logic in_win(addr_t addr, addr_t start);
    return (addr >= start) && (addr < start + addr_t'(`XDMA_WIN_SIZE));
  endfunction

  // local windows
  assign data_win  = xdma_win_addr(cluster_base_i, `XDMA_WIN_DATA);
  assign cfg_win   = xdma_win_addr(cluster_base_i, `XDMA_WIN_CFG);
  assign grant_win = xdma_win_addr(cluster_base_i, `XDMA_WIN_GRANT);

  // windows never overlap, at most one hit
  assign hit_data  = in_win(in_wr_i.addr, data_win);
  assign hit_cfg   = in_win(in_wr_i.addr, cfg_win);
  assign hit_grant = in_win(in_wr_i.addr, grant_win);

  // same word, three views
  assign data_o  = in_wr_i.data;
  assign cfg_o   = xdma_cfg_t'(in_wr_i.data);
  assign grant_o = xdma_grant_t'(in_wr_i.data);

  assign data_valid_o  = in_valid_i && hit_data;
  assign cfg_valid_o   = in_valid_i && hit_cfg;
  assign grant_valid_o = in_valid_i && hit_grant;

  // stray writes sink at once
  always_comb begin
    if (hit_data) begin
      in_ready_o = data_ready_i;
    end else if (hit_cfg) begin
      in_ready_o = cfg_ready_i;
    end else if (hit_grant) begin
      in_ready_o = grant_ready_i;
    end else begin
      in_ready_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/xdma_link_top.sv */
/*
 * xdma link top
 * cfg sender, grant issuer and data sender share the outbound
 * write bus through the arbiter, the receiver routes inbound
 * writes and feeds grants back to the data sender
 */
`timescale 1ns/1ps
`default_nettype none
`include "xdma_link_consts.svh"

module xdma_link_top
  import xdma_link_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  addr_t        cluster_base_i,
  // outbound message sources
  input  xdma_cfg_t    cfg_i,
  input  logic         cfg_valid_i,
  output logic         cfg_ready_o,
  input  xdma_accept_t accept_i,
  input  logic         accept_valid_i,
  output logic         accept_ready_o,
  input  xdma_burst_t  burst_i,
  input  logic         burst_valid_i,
  output logic         burst_ready_o,
  input  data_t        word_i,
  input  logic         word_valid_i,
  output logic         word_ready_o,
  output logic         done_o,
  // outbound bus
  output xdma_wr_t     out_wr_o,
  output logic         out_valid_o,
  input  logic         out_ready_i,
  // inbound bus and its outputs
  input  xdma_wr_t     in_wr_i,
  input  logic         in_valid_i,
  output logic         in_ready_o,
  output xdma_cfg_t    cfg_o,
  output logic         cfg_valid_o,
  input  logic         cfg_ready_i,
  output data_t        data_o,
  output logic         data_valid_o,
  input  logic         data_ready_i
);

  // ------------------------------------------------------------------
  // sender side, index 0 data, 1 cfg, 2 grant
  // ------------------------------------------------------------------
  xdma_wr_t                     snd_wr    [`XDMA_N_SENDERS];
  logic [`XDMA_N_SENDERS-1:0]   snd_valid;
  logic [`XDMA_N_SENDERS-1:0]   snd_ready;
  xdma_grant_t                  rx_grant;
  logic                         rx_grant_valid;
  logic                         rx_grant_ready;

  xdma_data_sender xdma_data_sender_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .burst_i       (burst_i),
    .burst_valid_i (burst_valid_i),
    .burst_ready_o (burst_ready_o),
    .word_i        (word_i),
    .word_valid_i  (word_valid_i),
    .word_ready_o  (word_ready_o),
    .grant_i       (rx_grant),
    .grant_valid_i (rx_grant_valid),
    .grant_ready_o (rx_grant_ready),
    .wr_o          (snd_wr[0]),
    .wr_valid_o    (snd_valid[0]),
    .wr_ready_i    (snd_ready[0]),
    .done_o        (done_o)
  );

  xdma_cfg_sender xdma_cfg_sender_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_i       (cfg_i),
    .cfg_valid_i (cfg_valid_i),
    .cfg_ready_o (cfg_ready_o),
    .wr_o        (snd_wr[1]),
    .wr_valid_o  (snd_valid[1]),
    .wr_ready_i  (snd_ready[1])
  );

  xdma_grant_issuer xdma_grant_issuer_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .accept_i       (accept_i),
    .accept_valid_i (accept_valid_i),
    .accept_ready_o (accept_ready_o),
    .cluster_base_i (cluster_base_i),
    .wr_o           (snd_wr[2]),
    .wr_valid_o     (snd_valid[2]),
    .wr_ready_i     (snd_ready[2])
  );

  xdma_write_arbiter #(
    .payload_t (xdma_wr_t),
    .NumReq    (`XDMA_N_SENDERS)
  ) xdma_write_arbiter_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (snd_wr),
    .req_valid_i (snd_valid),
    .req_ready_o (snd_ready),
    .oup_o       (out_wr_o),
    .oup_valid_o (out_valid_o),
    .oup_ready_i (out_ready_i)
  );

  // ------------------------------------------------------------------
  // receiver side
  // ------------------------------------------------------------------
  // grants go straight into the data sender store
  xdma_write_receiver xdma_write_receiver_inst (
    .cluster_base_i (cluster_base_i),
    .in_wr_i        (in_wr_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .cfg_o          (cfg_o),
    .cfg_valid_o    (cfg_valid_o),
    .cfg_ready_i    (cfg_ready_i),
    .data_o         (data_o),
    .data_valid_o   (data_valid_o),
    .data_ready_i   (data_ready_i),
    .grant_o        (rx_grant),
    .grant_valid_o  (rx_grant_valid),
    .grant_ready_i  (rx_grant_ready)
  );

endmodule

`default_nettype wire

/* bench/xdma_link_sva.sv */
/*
 * xdma link assertions
 * outbound handshake stability, single-cycle done pulse and
 * quiet outputs during reset, bound to the link top level
 */
`timescale 1ns/1ps
`default_nettype none

module xdma_link_sva
  import xdma_link_pkg::*;
(
  input logic     clk_i,
  input logic     arst_n_i,
  input xdma_wr_t out_wr_o,
  input logic     out_valid_o,
  input logic     out_ready_i,
  input logic     done_o,
  input logic     cfg_valid_o,
  input logic     data_valid_o
);

  // number of failed assertions
  int unsigned err_count = 0;

  // a stalled write keeps valid and payload
  property p_out_hold;
    @(posedge clk_i) disable iff (!arst_n_i)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_wr_o));
  endproperty

  // done is a pulse, never two cycles
  property p_done_pulse;
    @(posedge clk_i) disable iff (!arst_n_i)
      done_o |=> !done_o;
  endproperty

  property p_reset_quiet;
    @(posedge clk_i)
      !arst_n_i |-> (!out_valid_o && !done_o && !cfg_valid_o && !data_valid_o);
  endproperty

  a_out_hold: assert property (p_out_hold) else begin
    err_count++;
    $error("outbound write changed while stalled");
  end

  a_done_pulse: assert property (p_done_pulse) else begin
    err_count++;
    $error("done_o high for two cycles");
  end

  a_reset_quiet: assert property (p_reset_quiet) else begin
    err_count++;
    $error("output active during reset");
  end

endmodule

bind xdma_link_top xdma_link_sva xdma_link_sva_inst (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .out_wr_o     (out_wr_o),
  .out_valid_o  (out_valid_o),
  .out_ready_i  (out_ready_i),
  .done_o       (done_o),
  .cfg_valid_o  (cfg_valid_o),
  .data_valid_o (data_valid_o)
);

`default_nettype wire

/* bench/xdma_link_tb.sv */
/*
 * xdma link testbench
 * reads test steps from the tests file, drives the message channels
 * and the inbound bus, and matches outbound writes against the
 * expected set, burst words in order
 */
`timescale 1ns/1ps
`default_nettype none

module xdma_link_tb
  import xdma_link_pkg::*;
;

  logic         clk_i;
  logic         arst_n_i;
  addr_t        cluster_base_i;
  xdma_cfg_t    cfg_i;
  logic         cfg_valid_i;
  logic         cfg_ready_o;
  xdma_accept_t accept_i;
  logic         accept_valid_i;
  logic         accept_ready_o;
  xdma_burst_t  burst_i;
  logic         burst_valid_i;
  logic         burst_ready_o;
  data_t        word_i;
  logic         word_valid_i;
  logic         word_ready_o;
  logic         done_o;
  xdma_wr_t     out_wr_o;
  logic         out_valid_o;
  logic         out_ready_i;
  xdma_wr_t     in_wr_i;
  logic         in_valid_i;
  logic         in_ready_o;
  xdma_cfg_t    cfg_o;
  logic         cfg_valid_o;
  logic         cfg_ready_i;
  data_t        data_o;
  logic         data_valid_o;
  logic         data_ready_i;

  // ------------------------------------------------------------------
  // expected outbound writes and pending jobs
  // ------------------------------------------------------------------
  // cfg and grant writes, any order
  addr_t        exp_addr_q [$];
  data_t        exp_data_q [$];
  // burst words, strict order
  addr_t        burst_addr_q [$];
  data_t        burst_data_q [$];
  int unsigned  done_exp;
  int unsigned  done_seen;
  int unsigned  cycles;
  int unsigned  cycle_limit;
  logic         grant_sent;
  logic         has_cfg;
  logic         has_accept;
  logic         has_burst;
  logic         has_grant;
  xdma_cfg_t    pend_cfg;
  xdma_accept_t pend_accept;
  xdma_burst_t  pend_burst;
  data_t        pend_word0;
  xdma_wr_t     pend_grant;
  int unsigned  grant_gate;

  xdma_link_top xdma_link_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // one outbound write against the expected set
  task automatic match_write(input xdma_wr_t w);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_addr_q.size(); i++) begin
      if (idx < 0 && exp_addr_q[i] == w.addr && exp_data_q[i] == w.data) begin
        idx = i;
      end
    end
    if (idx >= 0) begin
      exp_addr_q.delete(idx);
      exp_data_q.delete(idx);
    end else if (burst_addr_q.size() != 0) begin
      if (!grant_sent) begin
        $display("burst word left at %0t ns before its grant arrived", $time);
        abort_run();
      end
      check_value("burst word address", w.addr, burst_addr_q[0]);
      check_value("burst word data", w.data, burst_data_q[0]);
      void'(burst_addr_q.pop_front());
      void'(burst_data_q.pop_front());
    end else if (exp_addr_q.size() != 0) begin
      check_value("outbound address", w.addr, exp_addr_q[0]);
      check_value("outbound data", w.data, exp_data_q[0]);
    end else begin
      $display("outbound write to %h at %0t ns with no write expected", w.addr, $time);
      abort_run();
    end
  endtask

  // sample just after the falling edge, settled until the next rise
  always begin
    @(negedge clk_i);
    #1;
    if (arst_n_i && out_valid_o && out_ready_i) begin
      match_write(out_wr_o);
    end
    if (arst_n_i && done_o) begin
      done_seen++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("run hung, no progress after %0d cycles", cycles);
      abort_run();
    end
  end

  // ------------------------------------------------------------------
  // channel drivers, valid held until ready seen before a rise
  // ------------------------------------------------------------------
  task automatic send_cfg();
    @(negedge clk_i);
    cfg_i       = pend_cfg;
    cfg_valid_i = 1'b1;
    #1;
    while (!cfg_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    cfg_valid_i = 1'b0;
  endtask

  task automatic send_accept();
    @(negedge clk_i);
    accept_i       = pend_accept;
    accept_valid_i = 1'b1;
    #1;
    while (!accept_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    accept_valid_i = 1'b0;
  endtask

  task automatic send_burst();
    @(negedge clk_i);
    burst_i       = pend_burst;
    burst_valid_i = 1'b1;
    #1;
    while (!burst_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    burst_valid_i = 1'b0;
  endtask

  task automatic send_words();
    for (int i = 0; i < pend_burst.len; i++) begin
      @(negedge clk_i);
      word_i       = pend_word0 + data_t'(i);
      word_valid_i = 1'b1;
      #1;
      while (!word_ready_o) begin
        @(negedge clk_i);
        #1;
      end
    end
    @(negedge clk_i);
    word_valid_i = 1'b0;
  endtask

  // returns with the write presented and accepted at the next rise
  task automatic drive_inbound(input xdma_wr_t w);
    @(negedge clk_i);
    in_wr_i    = w;
    in_valid_i = 1'b1;
    #1;
    while (!in_ready_o) begin
      @(negedge clk_i);
      #1;
    end
  endtask

  task automatic release_inbound();
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic send_grant();
    repeat (grant_gate) @(negedge clk_i);
    grant_sent = 1'b1;
    drive_inbound(pend_grant);
    release_inbound();
  endtask

  // outbound ready until every expected write and done pulse is seen
  task automatic pace_out_ready(input logic bp);
    logic [31:0] rnd;
    while (exp_addr_q.size() != 0 || burst_addr_q.size() != 0 || done_seen < done_exp) begin
      @(negedge clk_i);
      rnd         = $urandom;
      out_ready_i = bp ? rnd[0] : 1'b1;
    end
    out_ready_i = 1'b1;
  endtask

  task automatic run_jobs(input logic bp);
    done_seen = 0;
    fork
      if (has_cfg) send_cfg();
      if (has_accept) send_accept();
      if (has_burst) send_burst();
      if (has_burst) send_words();
      if (has_grant) send_grant();
      pace_out_ready(bp);
    join
    repeat (3) @(negedge clk_i);
    check_value("done pulses", done_seen, done_exp);
    has_cfg    = 1'b0;
    has_accept = 1'b0;
    has_burst  = 1'b0;
    has_grant  = 1'b0;
    grant_sent = 1'b0;
    done_exp   = 0;
  endtask

  initial begin : main
    int             fd;
    int unsigned    lines;
    logic [7:0]     step;
    logic [8*256-1:0] line_buf;
    logic [63:0]    a0;
    logic [63:0]    a1;
    logic [63:0]    a2;
    logic [63:0]    a3;
    logic [63:0]    a4;
    void'($urandom(32'h4753b7de));
    arst_n_i       = 1'b0;
    cluster_base_i = 32'h1020_0000;
    cfg_i          = '0;
    cfg_valid_i    = 1'b0;
    accept_i       = '0;
    accept_valid_i = 1'b0;
    burst_i        = '0;
    burst_valid_i  = 1'b0;
    word_i         = '0;
    word_valid_i   = 1'b0;
    out_ready_i    = 1'b1;
    in_wr_i        = '0;
    in_valid_i     = 1'b0;
    cfg_ready_i    = 1'b1;
    data_ready_i   = 1'b1;
    cycles         = 0;
    cycle_limit    = 0;
    done_exp       = 0;
    done_seen      = 0;
    grant_sent     = 1'b0;
    has_cfg        = 1'b0;
    has_accept     = 1'b0;
    has_burst      = 1'b0;
    has_grant      = 1'b0;
    lines          = 0;

    // timeout scales with the number of test lines
    fd = $fopen("bench/xdma_link_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the tests file");
      abort_run();
    end
    while ($fgets(line_buf, fd) != 0) begin
      lines++;
    end
    $fclose(fd);
    cycle_limit = 200 * lines;

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    fd = $fopen("bench/xdma_link_tests.txt", "r");
    while ($fscanf(fd, "%s", step) == 1) begin
      case (step)
        "#": void'($fgets(line_buf, fd));
        "C": begin
          void'($fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4));
          pend_cfg           = '0;
          pend_cfg.dma_id    = a0[7:0];
          pend_cfg.dma_type  = a1[0];
          pend_cfg.peer_addr = a2[31:0];
          exp_addr_q.push_back(a3[31:0]);
          exp_data_q.push_back(a4);
          has_cfg = 1'b1;
        end
        "A": begin
          void'($fscanf(fd, "%h %h %h %h", a0, a1, a2, a3));
          pend_accept.dma_id   = a0[7:0];
          pend_accept.src_addr = a1[31:0];
          exp_addr_q.push_back(a2[31:0]);
          exp_data_q.push_back(a3);
          has_accept = 1'b1;
        end
        "B": begin
          void'($fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4));
          pend_burst.dma_id   = a0[7:0];
          pend_burst.dst_addr = a1[31:0];
          pend_burst.len      = a2[7:0];
          pend_word0          = a3;
          // 8 bytes per word from the peer data window base
          for (int i = 0; i < a2[7:0]; i++) begin
            burst_addr_q.push_back(a4[31:0] + addr_t'(8 * i));
            burst_data_q.push_back(a3 + data_t'(i));
          end
          done_exp++;
          has_burst = 1'b1;
        end
        "G": begin
          void'($fscanf(fd, "%h %h %h", a0, a1, a2));
          pend_grant.addr = a0[31:0];
          pend_grant.data = a1;
          grant_gate      = a2;
          has_grant       = 1'b1;
        end
        "I": begin
          void'($fscanf(fd, "%h %h %h %h", a0, a1, a2, a3));
          drive_inbound('{addr: a0[31:0], data: a1});
          check_value("data_valid_o", data_valid_o, a2[0]);
          check_value("cfg_valid_o", cfg_valid_o, a3[0]);
          if (a2[0]) begin
            check_value("data_o", data_o, a1);
          end
          if (a3[0]) begin
            check_value("cfg_o", cfg_o, a1);
          end
          release_inbound();
        end
        "R": begin
          void'($fscanf(fd, "%h", a0));
          run_jobs(a0[0]);
        end
        default: begin
          $display("unknown step in the tests file");
          abort_run();
        end
      endcase
    end
    $fclose(fd);

    if (xdma_link_top_inst.xdma_link_sva_inst.err_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* bench/xdma_link_tests.txt */
# steps, hex fields: C id type peer exp_addr exp_data | A id src exp_addr exp_data
# B id dst len word0 exp_addr0 | G addr data gate | I addr data exp_dv exp_cv | R bp
# configuration send
C 21 1 10451234 104fe000 218822891a000000
R 0
# grant issue
A 33 10100000 101fd000 3310200000000000
R 0
# inbound routing
I 102ff000 0123456789abcdef 1 0
I 102ff018 fedcba9876543210 1 0
I 102fe000 218822891a000000 0 1
I 10200000 00000000deadbeef 0 0
# grant-gated burst
B 05 10450000 3 a000000000000000 104ff000
G 102fd000 0510400000000000 20
R 0
# back-pressure and sharing
C 44 0 10630010 106fe000 4408318008000000
A 66 10712345 107fd000 6610200000000000
B 07 10310000 4 b000000000000010 103ff000
G 102fd000 0710300000000000 3
R 1

/* xdma_link.f */
+incdir+hdl
hdl/xdma_link_pkg.sv
hdl/xdma_cfg_sender.sv
hdl/xdma_grant_issuer.sv
hdl/xdma_data_sender.sv
hdl/xdma_write_arbiter.sv
hdl/xdma_write_receiver.sv
hdl/xdma_link_top.sv
bench/xdma_link_sva.sv
bench/xdma_link_tb.sv
